// File: design/rv_decode_defs.svh
// architectural widths of rv32i, not meant to be retuned on their own
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// data and register width
`define XLEN 32

// register index width and count
`define REG_ADDR_W 5
`define NUM_REGS 32

// major opcode field, instr[6:0]
`define OPCODE_W 7

`endif

// File: design/rv_isa_pkg.sv
// rv32i encodings only, compressed forms are expanded before they reach these types
`default_nettype none

`include "rv_decode_defs.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes of the base set
    typedef enum logic [`OPCODE_W-1:0] {
        OPC_LOAD     = 7'h03,
        OPC_MISC_MEM = 7'h0f,
        OPC_OP_IMM   = 7'h13,
        OPC_AUIPC    = 7'h17,
        OPC_STORE    = 7'h23,
        OPC_OP       = 7'h33,
        OPC_LUI      = 7'h37,
        OPC_BRANCH   = 7'h63,
        OPC_JALR     = 7'h67,
        OPC_JAL      = 7'h6f,
        OPC_SYSTEM   = 7'h73
    } opcode_e;

endpackage

`default_nettype wire

// File: design/rv_pipe_pkg.sv
// one instruction per stage slot, valid strobes only and no ready handshake
`default_nettype none

`include "rv_decode_defs.svh"

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // micro-operation, nop marks illegal or flushed slots
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC,
        OP_FENCE, OP_ECALL, OP_EBREAK
    } op_e;

    // source of a register operand
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EX   = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    // raw fetch, only instr[15:0] counts when compressed
    typedef struct packed {
        logic   valid;
        instr_t instr;
        word_t  pc;
    } fetch_pkt_t;

    // stage-1 register contents
    typedef struct packed {
        logic   valid;
        instr_t instr;
        word_t  pc;
        word_t  link;
        logic   rvc_illegal;
    } expanded_pkt_t;

    typedef struct packed {
        op_e       op;
        logic      use_pc;
        logic      use_imm;
        word_t     imm;
        reg_addr_t rd;
        logic      illegal;
    } uop_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_pkt_t;

    // handed to execute
    typedef struct packed {
        logic      valid;
        op_e       op;
        word_t     op_a;
        word_t     op_b;
        reg_addr_t rd;
        word_t     link;
        logic      lt;
        logic      ltu;
        logic      eq;
        logic      illegal;
    } issue_pkt_t;

endpackage

`default_nettype wire

// File: design/rvc_expander.sv
// rv32c quadrants 0 to 2 only, a strobe that arrives during stall is dropped
`default_nettype none

module rvc_expander
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          reset_i,
    input  wire fetch_pkt_t    fetch_i,
    input  wire logic          stall_i,
    input  wire logic          flush_i,
    output expanded_pkt_t      exp_o
);

    logic [15:0]   c;
    logic          is_rvc;
    reg_addr_t     rdp;
    reg_addr_t     rs1p;
    logic [11:0]   ci_imm;
    instr_t        exp_instr;
    logic          rvc_ill;
    expanded_pkt_t exp_q;

    assign c      = fetch_i.instr[15:0];
    assign is_rvc = (c[1:0] != 2'b11);
    // compressed register fields map to x8..x15
    assign rdp    = {2'b01, c[4:2]};
    assign rs1p   = {2'b01, c[9:7]};
    // 6-bit signed ci immediate
    assign ci_imm = {{7{c[12]}}, c[6:2]};

    always_comb begin
        exp_instr = fetch_i.instr;
        rvc_ill   = 1'b0;
        if (is_rvc) begin
            // reserved slots fall out as opcode zero
            exp_instr = '0;
            case ({c[1:0], c[15:13]})
                // c.addi4spn, zero immediate also catches the all-zero word
                5'b00_000: begin
                    exp_instr = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                                 5'd2, 3'b000, rdp, OPC_OP_IMM};
                    rvc_ill   = (c[12:5] == 8'd0);
                end
                // c.lw
                5'b00_010: exp_instr = {5'b0, c[5], c[12:10], c[6], 2'b00,
                                        rs1p, 3'b010, rdp, OPC_LOAD};
                // c.sw
                5'b00_110: exp_instr = {5'b0, c[5], c[12], rdp, rs1p, 3'b010,
                                        c[11:10], c[6], 2'b00, OPC_STORE};
                // c.addi, c.nop
                5'b01_000: exp_instr = {ci_imm, c[11:7], 3'b000, c[11:7], OPC_OP_IMM};
                // c.jal links x1, c.j links x0
                5'b01_001, 5'b01_101: begin
                    exp_instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                 c[12], {8{c[12]}}, 4'b0000, ~c[15], OPC_JAL};
                end
                // c.li
                5'b01_010: exp_instr = {ci_imm, 5'd0, 3'b000, c[11:7], OPC_OP_IMM};
                5'b01_011: begin
                    if (c[11:7] == 5'd2) begin
                        // c.addi16sp
                        exp_instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                                     5'd2, 3'b000, 5'd2, OPC_OP_IMM};
                    end else begin
                        // c.lui
                        exp_instr = {{15{c[12]}}, c[6:2], c[11:7], OPC_LUI};
                    end
                    rvc_ill = ({c[12], c[6:2]} == 6'd0);
                end
                5'b01_100: begin
                    case (c[11:10])
                        // c.srli, c.srai
                        2'b00, 2'b01: begin
                            exp_instr = {1'b0, c[10], 5'b0, c[6:2], rs1p, 3'b101,
                                         rs1p, OPC_OP_IMM};
                            rvc_ill   = c[12] | (c[6:2] == 5'd0);
                        end
                        // c.andi
                        2'b10: exp_instr = {ci_imm, rs1p, 3'b111, rs1p, OPC_OP_IMM};
                        // c.sub, c.xor, c.or, c.and
                        default: begin
                            exp_instr = {1'b0, (c[6:5] == 2'b00), 5'b0, rdp, rs1p,
                                         3'b000, rs1p, OPC_OP};
                            case (c[6:5])
                                2'b01:   exp_instr[14:12] = 3'b100;
                                2'b10:   exp_instr[14:12] = 3'b110;
                                2'b11:   exp_instr[14:12] = 3'b111;
                                default: exp_instr[14:12] = 3'b000;
                            endcase
                            // c[12] set is the rv64 word form
                            rvc_ill = c[12];
                        end
                    endcase
                end
                // c.beqz, c.bnez
                5'b01_110, 5'b01_111: begin
                    exp_instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 2'b00, c[13],
                                 c[11:10], c[4:3], c[12], OPC_BRANCH};
                end
                // c.slli
                5'b10_000: begin
                    exp_instr = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], OPC_OP_IMM};
                    rvc_ill   = c[12] | (c[6:2] == 5'd0);
                end
                // c.lwsp, x0 destination reserved
                5'b10_010: begin
                    exp_instr = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010,
                                 c[11:7], OPC_LOAD};
                    rvc_ill   = (c[11:7] == 5'd0);
                end
                5'b10_100: begin
                    if (c[6:2] == 5'd0) begin
                        if (!c[12]) begin
                            // c.jr
                            exp_instr = {12'b0, c[11:7], 3'b000, 5'd0, OPC_JALR};
                            rvc_ill   = (c[11:7] == 5'd0);
                        end else if (c[11:7] == 5'd0) begin
                            // c.ebreak
                            exp_instr = 32'h0010_0073;
                        end else begin
                            // c.jalr
                            exp_instr = {12'b0, c[11:7], 3'b000, 5'd1, OPC_JALR};
                        end
                    end else begin
                        // c.mv reads x0, c.add reads rd
                        exp_instr = {7'b0, c[6:2], c[11:7] & {5{c[12]}}, 3'b000,
                                     c[11:7], OPC_OP};
                    end
                end
                // c.swsp
                5'b10_110: exp_instr = {4'b0, c[8:7], c[12], c[6:2], 5'd2, 3'b010,
                                        c[11:9], 2'b00, OPC_STORE};
                default: rvc_ill = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            exp_q.instr       <= exp_instr;
            exp_q.pc          <= fetch_i.pc;
            exp_q.link        <= fetch_i.pc + (is_rvc ? 32'd2 : 32'd4);
            exp_q.rvc_illegal <= rvc_ill;
        end
        // flush wins over stall
        if (reset_i || flush_i) begin
            exp_q.valid <= 1'b0;
        end else if (!stall_i) begin
            exp_q.valid <= fetch_i.valid;
        end
    end

    assign exp_o = exp_q;

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
// rv32i base only, csr access and fence.i decode as illegal
`default_nettype none

module instr_decoder
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire expanded_pkt_t exp_i,
    output uop_t               uop_o,
    output reg_addr_t          rs1_addr_o,
    output reg_addr_t          rs2_addr_o
);

    instr_t     ins;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    op_e        op;
    logic       bad;
    logic       has_rd;
    logic       use_pc;
    logic       use_imm;
    word_t      imm;
    logic       illegal;

    assign ins   = exp_i.instr;
    assign f3    = ins[14:12];
    assign f7    = ins[31:25];
    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        op      = OP_NOP;
        bad     = 1'b0;
        has_rd  = 1'b1;
        use_pc  = 1'b0;
        use_imm = 1'b1;
        imm     = imm_i;
        case (opcode_e'(ins[6:0]))
            OPC_LUI: begin
                op  = OP_LUI;
                imm = imm_u;
            end
            OPC_AUIPC: begin
                op     = OP_AUIPC;
                use_pc = 1'b1;
                imm    = imm_u;
            end
            OPC_JAL: begin
                op     = OP_JAL;
                use_pc = 1'b1;
                imm    = imm_j;
            end
            OPC_JALR: begin
                op  = OP_JALR;
                bad = (f3 != 3'b000);
            end
            OPC_BRANCH: begin
                has_rd = 1'b0;
                imm    = imm_b;
                case (f3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                case (f3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_STORE: begin
                has_rd = 1'b0;
                imm    = imm_s;
                case (f3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: bad = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                case (f3)
                    3'b000:  op = OP_ADDI;
                    3'b010:  op = OP_SLTI;
                    3'b011:  op = OP_SLTIU;
                    3'b100:  op = OP_XORI;
                    3'b110:  op = OP_ORI;
                    3'b111:  op = OP_ANDI;
                    3'b001: begin
                        op  = OP_SLLI;
                        bad = (f7 != 7'h00);
                    end
                    default: begin
                        // shift right, bit 30 picks arithmetic
                        op  = (f7 == 7'h20) ? OP_SRAI : OP_SRLI;
                        bad = (f7 != 7'h00) && (f7 != 7'h20);
                    end
                endcase
            end
            OPC_OP: begin
                use_imm = 1'b0;
                case ({f7, f3})
                    10'h000: op = OP_ADD;
                    10'h100: op = OP_SUB;
                    10'h001: op = OP_SLL;
                    10'h002: op = OP_SLT;
                    10'h003: op = OP_SLTU;
                    10'h004: op = OP_XOR;
                    10'h005: op = OP_SRL;
                    10'h105: op = OP_SRA;
                    10'h006: op = OP_OR;
                    10'h007: op = OP_AND;
                    default: bad = 1'b1;
                endcase
            end
            OPC_MISC_MEM: begin
                op     = OP_FENCE;
                has_rd = 1'b0;
                bad    = (f3 != 3'b000);
            end
            OPC_SYSTEM: begin
                has_rd = 1'b0;
                case (ins)
                    32'h0000_0073: op = OP_ECALL;
                    32'h0010_0073: op = OP_EBREAK;
                    default:       bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;
        endcase
    end

    assign illegal = bad | exp_i.rvc_illegal;

    // illegal slots carry no operation and no destination
    assign uop_o.op      = illegal ? OP_NOP : op;
    assign uop_o.use_pc  = use_pc;
    assign uop_o.use_imm = use_imm;
    assign uop_o.imm     = imm;
    assign uop_o.rd      = (has_rd && !illegal) ? ins[11:7] : '0;
    assign uop_o.illegal = illegal;

    assign rs1_addr_o = ins[19:15];
    assign rs2_addr_o = ins[24:20];

endmodule

`default_nettype wire

// File: design/reg_file.sv
// reads are combinational and return the old value during a same-cycle write
`default_nettype none

`include "rv_decode_defs.svh"

module reg_file
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      reset_i,
    input  wire reg_addr_t rs1_addr_i,
    input  wire reg_addr_t rs2_addr_i,
    output word_t          rs1_data_o,
    output word_t          rs2_data_o,
    input  wire wb_pkt_t   wb_i
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.addr != '0)) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: design/operand_issue.sv
// forwarding selects refer to the instruction held in stage 2 this cycle
`default_nettype none

module operand_issue
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          reset_i,
    input  wire expanded_pkt_t exp_i,
    input  wire uop_t          uop_i,
    input  wire word_t         rs1_data_i,
    input  wire word_t         rs2_data_i,
    input  wire word_t         ex_fwd_data_i,
    input  wire wb_pkt_t       wb_i,
    input  wire fwd_sel_e      fwd_sel1_i,
    input  wire fwd_sel_e      fwd_sel2_i,
    input  wire logic          stall_i,
    input  wire logic          flush_i,
    output issue_pkt_t         issue_o
);

    word_t      rs1_fwd;
    word_t      rs2_fwd;
    issue_pkt_t issue_d;
    issue_pkt_t issue_q;

    // one mux per source register
    function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val, word_t ex_val,
                                      word_t wb_val);
        case (sel)
            FWD_EX:  return ex_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign rs1_fwd = fwd_mux(fwd_sel1_i, rs1_data_i, ex_fwd_data_i, wb_i.data);
    assign rs2_fwd = fwd_mux(fwd_sel2_i, rs2_data_i, ex_fwd_data_i, wb_i.data);

    assign issue_d.valid   = exp_i.valid;
    assign issue_d.op      = uop_i.op;
    assign issue_d.op_a    = uop_i.use_pc ? exp_i.pc : rs1_fwd;
    // immediate never forwarded
    assign issue_d.op_b    = uop_i.use_imm ? uop_i.imm : rs2_fwd;
    assign issue_d.rd      = uop_i.rd;
    assign issue_d.link    = exp_i.link;
    // flags always on register values
    assign issue_d.lt      = $signed(rs1_fwd) < $signed(rs2_fwd);
    assign issue_d.ltu     = rs1_fwd < rs2_fwd;
    assign issue_d.eq      = rs1_fwd == rs2_fwd;
    assign issue_d.illegal = uop_i.illegal;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            issue_q <= '0;
        end else if (flush_i) begin
            issue_q.valid <= 1'b0;
            issue_q.op    <= OP_NOP;
        end else if (!stall_i) begin
            // empty stage 1 becomes a zero bubble
            issue_q <= exp_i.valid ? issue_d : '0;
        end
    end

    assign issue_o = issue_q;

endmodule

`default_nettype wire

// File: design/decode_stage.sv
// two-cycle latency from fetch strobe to issue, stall is the only back-pressure
`default_nettype none

module decode_stage
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    input  wire fetch_pkt_t fetch_i,
    input  wire wb_pkt_t    wb_i,
    input  wire word_t      ex_fwd_data_i,
    input  wire fwd_sel_e   fwd_sel1_i,
    input  wire fwd_sel_e   fwd_sel2_i,
    input  wire logic       stall_i,
    input  wire logic       flush_i,
    output reg_addr_t       rs1_addr_o,
    output reg_addr_t       rs2_addr_o,
    output issue_pkt_t      issue_o
);

    expanded_pkt_t exp;
    uop_t          uop;
    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;
    word_t         rs1_data;
    word_t         rs2_data;

    // stage 1
    rvc_expander rvc_expander_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .fetch_i (fetch_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .exp_o   (exp)
    );

    // stage 2 decode and read
    instr_decoder instr_decoder_i (
        .exp_i      (exp),
        .uop_o      (uop),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr)
    );

    reg_file reg_file_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i)
    );

    operand_issue operand_issue_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .exp_i         (exp),
        .uop_i         (uop),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_fwd_data_i (ex_fwd_data_i),
        .wb_i          (wb_i),
        .fwd_sel1_i    (fwd_sel1_i),
        .fwd_sel2_i    (fwd_sel2_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .issue_o       (issue_o)
    );

    // hazard unit compares these against ex and wb destinations
    assign rs1_addr_o = rs1_addr;
    assign rs2_addr_o = rs2_addr;

endmodule

`default_nettype wire

// File: tests/decode_stage_tb.sv
// expects the fixed two-cycle latency and flags on the forwarded register values
`default_nettype none

`include "rv_decode_defs.svh"

module decode_stage_tb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        string    name;
        instr_t   instr;
        word_t    pc;
        fwd_sel_e sel1;
        fwd_sel_e sel2;
        word_t    fwd;
        op_e      op;
        word_t    op_a;
        word_t    op_b;
        logic [4:0] rd;
        word_t    link;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic     ill;
    } row_t;

    logic       clk_i = 1'b0;
    logic       reset_i = 1'b1;
    fetch_pkt_t fetch = '0;
    wb_pkt_t    wb = '0;
    word_t      ex_fwd = '0;
    fwd_sel_e   sel1 = FWD_NONE;
    fwd_sel_e   sel2 = FWD_NONE;
    logic       stall = 1'b0;
    logic       flush = 1'b0;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    issue_pkt_t issue;

    word_t      m [`NUM_REGS];
    row_t       rows [$];
    int         errors = 0;
    logic [31:0] lfsr = 32'd25;

    decode_stage decode_stage_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_i       (fetch),
        .wb_i          (wb),
        .ex_fwd_data_i (ex_fwd),
        .fwd_sel1_i    (sel1),
        .fwd_sel2_i    (sel2),
        .stall_i       (stall),
        .flush_i       (flush),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .issue_o       (issue)
    );

    always #10 clk_i = ~clk_i;

    // taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ex port carries the row value and wb port its inverse
    function automatic word_t source_value(input fwd_sel_e sel, input reg_addr_t a,
                                           input word_t fwd);
        case (sel)
            FWD_EX:  return fwd;
            FWD_WB:  return ~fwd;
            default: return m[a];
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic add_row(input string name, input instr_t instr, input word_t pc,
                           input fwd_sel_e s1, input fwd_sel_e s2, input word_t fwd,
                           input op_e op, input word_t a, input word_t b,
                           input logic [4:0] rd, input word_t link, input reg_addr_t rs1,
                           input reg_addr_t rs2, input logic ill);
        row_t r;
        r = '{name, instr, pc, s1, s2, fwd, op, a, b, rd, link, rs1, rs2, ill};
        rows.push_back(r);
    endtask

    task automatic strobe(input row_t r);
        fetch.valid = 1'b1;
        fetch.instr = r.instr;
        fetch.pc    = r.pc;
    endtask

    task automatic compare_issue(input row_t r);
        word_t r1v;
        word_t r2v;
        r1v = source_value(r.sel1, r.rs1, r.fwd);
        r2v = source_value(r.sel2, r.rs2, r.fwd);
        check({r.name, ".valid"}, 32'd1, 32'(issue.valid));
        check({r.name, ".op"}, 32'(r.op), 32'(issue.op));
        check({r.name, ".illegal"}, 32'(r.ill), 32'(issue.illegal));
        // operands of an illegal slot carry no meaning
        if (!r.ill) begin
            check({r.name, ".op_a"}, r.op_a, issue.op_a);
            check({r.name, ".op_b"}, r.op_b, issue.op_b);
            check({r.name, ".rd"}, 32'(r.rd), 32'(issue.rd));
            check({r.name, ".link"}, r.link, issue.link);
            check({r.name, ".lt"}, 32'($signed(r1v) < $signed(r2v)), 32'(issue.lt));
            check({r.name, ".ltu"}, 32'(r1v < r2v), 32'(issue.ltu));
            check({r.name, ".eq"}, 32'(r1v == r2v), 32'(issue.eq));
        end
    endtask

    // selects follow the strobe by one cycle and the result by two
    task automatic run_row(input row_t r);
        @(posedge clk_i);
        #1;
        strobe(r);
        @(posedge clk_i);
        #1;
        fetch.valid = 1'b0;
        sel1        = r.sel1;
        sel2        = r.sel2;
        ex_fwd      = r.fwd;
        // wb differs from ex so a swapped select shows up
        wb.data     = ~r.fwd;
        if (!r.ill) begin
            check({r.name, ".rs1_addr"}, 32'(r.rs1), 32'(rs1_addr));
            check({r.name, ".rs2_addr"}, 32'(r.rs2), 32'(rs2_addr));
        end
        @(posedge clk_i);
        #1;
        sel1 = FWD_NONE;
        sel2 = FWD_NONE;
        compare_issue(r);
    endtask

    task automatic fill_table();
        // full width
        add_row("add", 32'h002081B3, 32'h100, FWD_NONE, FWD_NONE, 0, OP_ADD,
                m[1], m[2], 3, 32'h104, 1, 2, 0);
        add_row("addi", 32'hFFB30293, 32'h104, FWD_NONE, FWD_NONE, 0, OP_ADDI,
                m[6], 32'hFFFFFFFB, 5, 32'h108, 6, 27, 0);
        add_row("lw", 32'h00812383, 32'h108, FWD_NONE, FWD_NONE, 0, OP_LW,
                m[2], 32'd8, 7, 32'h10C, 2, 8, 0);
        add_row("sw", 32'h00922623, 32'h10C, FWD_NONE, FWD_NONE, 0, OP_SW,
                m[4], 32'd12, 0, 32'h110, 4, 9, 0);
        add_row("lui", 32'h12345537, 32'h110, FWD_NONE, FWD_NONE, 0, OP_LUI,
                m[8], 32'h12345000, 10, 32'h114, 8, 3, 0);
        add_row("auipc", 32'h00001597, 32'h114, FWD_NONE, FWD_NONE, 0, OP_AUIPC,
                32'h114, 32'h1000, 11, 32'h118, 0, 0, 0);
        add_row("jal", 32'h010000EF, 32'h118, FWD_NONE, FWD_NONE, 0, OP_JAL,
                32'h118, 32'd16, 1, 32'h11C, 0, 16, 0);
        add_row("beq", 32'hFE208CE3, 32'h11C, FWD_NONE, FWD_NONE, 0, OP_BEQ,
                m[1], 32'hFFFFFFF8, 0, 32'h120, 1, 2, 0);
        // compressed forms link at pc plus 2
        add_row("c.addi", 32'h1475, 32'h200, FWD_NONE, FWD_NONE, 0, OP_ADDI,
                m[8], 32'hFFFFFFFD, 8, 32'h202, 8, 29, 0);
        add_row("c.lw", 32'h4144, 32'h202, FWD_NONE, FWD_NONE, 0, OP_LW,
                m[10], 32'd4, 9, 32'h204, 10, 4, 0);
        add_row("c.swsp", 32'hC416, 32'h204, FWD_NONE, FWD_NONE, 0, OP_SW,
                m[2], 32'd8, 0, 32'h206, 2, 5, 0);
        add_row("c.beqz", 32'hC019, 32'h206, FWD_NONE, FWD_NONE, 0, OP_BEQ,
                m[8], 32'd6, 0, 32'h208, 8, 0, 0);
        add_row("c.jal", 32'h2021, 32'h208, FWD_NONE, FWD_NONE, 0, OP_JAL,
                32'h208, 32'd8, 1, 32'h20A, 0, 8, 0);
        add_row("c.mv", 32'h8636, 32'h20A, FWD_NONE, FWD_NONE, 0, OP_ADD,
                0, m[13], 12, 32'h20C, 0, 13, 0);
        // reserved and unknown encodings
        add_row("c.zero", 32'h0000, 32'h300, FWD_NONE, FWD_NONE, 0, OP_NOP,
                0, 0, 0, 0, 0, 0, 1);
        add_row("c.lwsp.x0", 32'h4012, 32'h302, FWD_NONE, FWD_NONE, 0, OP_NOP,
                0, 0, 0, 0, 0, 0, 1);
        add_row("c.slli.0", 32'h0282, 32'h304, FWD_NONE, FWD_NONE, 0, OP_NOP,
                0, 0, 0, 0, 0, 0, 1);
        add_row("custom0", 32'h0000000B, 32'h306, FWD_NONE, FWD_NONE, 0, OP_NOP,
                0, 0, 0, 0, 0, 0, 1);
        // forwarding
        // -1 against zero splits signed and unsigned
        add_row("fwd.ex.a", 32'h000081B3, 32'h400, FWD_EX, FWD_NONE, 32'hFFFFFFFF, OP_ADD,
                32'hFFFFFFFF, 0, 3, 32'h404, 1, 0, 0);
        add_row("fwd.wb.b", 32'h002081B3, 32'h404, FWD_NONE, FWD_WB, 32'hFFFFFFAA, OP_ADD,
                m[1], 32'h55, 3, 32'h408, 1, 2, 0);
        add_row("fwd.ex.b", 32'h002081B3, 32'h408, FWD_NONE, FWD_EX, 32'h77, OP_ADD,
                m[1], 32'h77, 3, 32'h40C, 1, 2, 0);
        add_row("fwd.imm", 32'hFFB30293, 32'h40C, FWD_WB, FWD_EX, 32'h1234, OP_ADDI,
                32'hFFFFEDCB, 32'hFFFFFFFB, 5, 32'h410, 6, 27, 0);
        // x0 was written during preload
        add_row("x0.read", 32'h002001B3, 32'h500, FWD_NONE, FWD_NONE, 0, OP_ADD,
                0, m[2], 3, 32'h504, 0, 2, 0);
    endtask

    initial begin : watchdog
        int cycles;
        #1;
        cycles = rows.size() * 4 + `NUM_REGS + 20;
        #(cycles * 20);
        $display("watchdog expired after %0d cycles, the tests did not finish", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        issue_pkt_t held;
        m[0] = '0;
        for (int i = 1; i < `NUM_REGS; i++) begin
            for (int b = 0; b < `XLEN; b++) begin
                lfsr    = lfsr_step(lfsr);
                m[i][b] = lfsr[0];
            end
        end
        fill_table();

        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        check("reset.valid", 32'd0, 32'(issue.valid));
        check("reset.op_a", 32'd0, issue.op_a);

        // preload through the writeback port and then write x0
        wb.we = 1'b1;
        for (int i = 1; i < `NUM_REGS; i++) begin
            wb.addr = reg_addr_t'(i);
            wb.data = m[i];
            @(posedge clk_i);
            #1;
        end
        wb.addr = '0;
        wb.data = 32'hDEADBEEF;
        @(posedge clk_i);
        #1;
        wb.we = 1'b0;

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        // stall holds issue and drops the new strobe
        held = issue;
        stall = 1'b1;
        strobe(rows[1]);
        repeat (3) begin
            @(posedge clk_i);
            #1;
            check("stall.op", 32'(held.op), 32'(issue.op));
            check("stall.op_a", held.op_a, issue.op_a);
            check("stall.valid", 32'(held.valid), 32'(issue.valid));
        end
        stall       = 1'b0;
        fetch.valid = 1'b0;
        @(posedge clk_i);
        #1;
        check("stall.drop", 32'd0, 32'(issue.valid));

        // flush while the instruction sits in stage 2
        strobe(rows[0]);
        @(posedge clk_i);
        #1;
        // strobe during flush is cleared in stage 1
        strobe(rows[2]);
        flush = 1'b1;
        @(posedge clk_i);
        #1;
        flush       = 1'b0;
        fetch.valid = 1'b0;
        check("flush.valid", 32'd0, 32'(issue.valid));
        check("flush.op", 32'(OP_NOP), 32'(issue.op));
        @(posedge clk_i);
        #1;
        check("flush.stage1", 32'd0, 32'(issue.valid));

        // back to back
        strobe(rows[0]);
        @(posedge clk_i);
        #1;
        strobe(rows[2]);
        @(posedge clk_i);
        #1;
        fetch.valid = 1'b0;
        compare_issue(rows[0]);
        @(posedge clk_i);
        #1;
        compare_issue(rows[2]);

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rvc_expander.sv
design/instr_decoder.sv
design/reg_file.sv
design/operand_issue.sv
design/decode_stage.sv
tests/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module decode_stage_tb -f verilog.f
out=$(./obj_dir/Vdecode_stage_tb)
echo "$out"
if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
